//--- include/bch_defines.svh
`ifndef BCH_DEFINES_SVH
`define BCH_DEFINES_SVH

// Degree of the field GF(2^m).
`define BCH_M 4

// Codeword length, 2^m - 1.
`define BCH_N 15

// Field polynomial x^4 + x + 1, m+1 bits.
`define BCH_POLY 5'b1_0011

// Odd syndromes needed for t = 2 (S1 and S3).
`define BCH_NSYN 2

`endif

//--- hdl/gf_pkg.sv
`default_nettype none

package gf_pkg;
	`include "bch_defines.svh"

	// Standard basis element, bit 0 is the alpha^0 coefficient.
	typedef logic [`BCH_M-1:0] gf_elem_t;

	localparam logic [`BCH_M:0] FIELD_POLY = `BCH_POLY;

	// Shift up one power, fold the overflow back in.
	function automatic gf_elem_t gf_mul_alpha(input gf_elem_t a);
		return {a[`BCH_M-2:0], 1'b0} ^ ({`BCH_M{a[`BCH_M-1]}} & FIELD_POLY[`BCH_M-1:0]);
	endfunction

	// MSB-first shift and add multiplier.
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t p;
		p = '0;
		for (int i = `BCH_M - 1; i >= 0; i--) begin
			p = gf_mul_alpha(p) ^ (a & {`BCH_M{b[i]}});
		end
		return p;
	endfunction

	function automatic gf_elem_t gf_sqr(input gf_elem_t a);
		return gf_mul(a, a);
	endfunction
endpackage

`default_nettype wire

//--- hdl/bch_pkg.sv
`default_nettype none

package bch_pkg;
	`include "bch_defines.svh"

	// Received word, bit N-1 arrives first.
	typedef logic [`BCH_N-1:0] cw_t;

	// Bit position within a codeword.
	typedef logic [3:0] pos_t;

	// Error count, 3 marks an uncorrectable word.
	typedef logic [1:0] err_cnt_t;

	localparam err_cnt_t ERR_FAIL = 2'd3;
endpackage

`default_nettype wire

//--- hdl/gf_divider.sv
`default_nettype none

`include "bch_defines.svh"

module gf_divider (
	input wire clk,
	input wire reset,
	input wire start,
	input wire gf_pkg::gf_elem_t numer,
	input wire gf_pkg::gf_elem_t denom,
	output gf_pkg::gf_elem_t quot,
	output logic busy,
	output logic done
);
	localparam int STEP_W = $clog2(`BCH_M);
	// Step that applies the numerator.
	localparam logic [STEP_W-1:0] NUMER_STEP = STEP_W'(`BCH_M - 2);
	// Last busy cycle, carries the done pulse.
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`BCH_M - 1);

	logic [STEP_W-1:0] step;
	gf_pkg::gf_elem_t denom_sq;
	// Running square d^(2^k).
	gf_pkg::gf_elem_t sq;
	// Partial inverse, product of the squares so far.
	gf_pkg::gf_elem_t acc;
	gf_pkg::gf_elem_t numer_q;

	assign denom_sq = gf_pkg::gf_sqr(denom);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (step == NUMER_STEP)
					done <= 1'b1;
				if (step == LAST_STEP)
					busy <= 1'b0;
			end
		end
	end

	// Fermat inverse, d^-1 = d^2 * d^4 * ... * d^(2^(m-1)).
	// Zero denominator stays zero all the way through.
	always_ff @(posedge clk) begin
		if (start) begin
			acc <= denom_sq;
			sq <= gf_pkg::gf_sqr(denom_sq);
			numer_q <= numer;
		end else if (busy) begin
			if (step < NUMER_STEP) begin
				acc <= gf_pkg::gf_mul(acc, sq);
				sq <= gf_pkg::gf_sqr(sq);
			end else if (step == NUMER_STEP) begin
				quot <= gf_pkg::gf_mul(acc, numer_q);
			end
		end
	end

	// Single issue unit, no overlap of operations.
	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy);
endmodule

`default_nettype wire

//--- hdl/bch_syndrome.sv
`default_nettype none

`include "bch_defines.svh"

module bch_syndrome (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire in_first,
	input wire in_bit,
	output logic syn_done,
	output gf_pkg::gf_elem_t syn_s1,
	output gf_pkg::gf_elem_t syn_s3,
	output bch_pkg::cw_t syn_word
);
	localparam bch_pkg::pos_t LAST_POS = bch_pkg::pos_t'(`BCH_N - 1);

	// One Horner accumulator per odd syndrome.
	gf_pkg::gf_elem_t acc [`BCH_NSYN];
	gf_pkg::gf_elem_t acc_next [`BCH_NSYN];
	bch_pkg::cw_t word;
	bch_pkg::cw_t word_next;
	bch_pkg::pos_t cnt;
	bch_pkg::pos_t cnt_cur;

	// in_first forces a fresh word.
	assign cnt_cur = in_first ? '0 : cnt;
	assign word_next = {word[`BCH_N-2:0], in_bit};

	// acc = acc * alpha^(2i+1) + bit.
	always_comb begin : horner
		gf_pkg::gf_elem_t prod;
		for (int i = 0; i < `BCH_NSYN; i++) begin
			prod = (cnt_cur == '0) ? '0 : acc[i];
			for (int j = 0; j < 2 * i + 1; j++) begin
				prod = gf_pkg::gf_mul_alpha(prod);
			end
			acc_next[i] = prod ^ gf_pkg::gf_elem_t'(in_bit);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			syn_done <= 1'b0;
		end else begin
			syn_done <= in_valid && (cnt_cur == LAST_POS);
			if (in_valid)
				cnt <= (cnt_cur == LAST_POS) ? '0 : cnt_cur + 1'b1;
		end
	end

	// Results held until the next word completes.
	always_ff @(posedge clk) begin
		if (in_valid) begin
			acc <= acc_next;
			word <= word_next;
			if (cnt_cur == LAST_POS) begin
				syn_s1 <= acc_next[0];
				syn_s3 <= acc_next[1];
				syn_word <= word_next;
			end
		end
	end

	// Word framing must agree with the bit count.
	a_first_aligned: assert property (@(posedge clk) disable iff (reset)
		in_valid && in_first |-> cnt == '0);
endmodule

`default_nettype wire

//--- hdl/bch_key_solver.sv
`default_nettype none

`include "bch_defines.svh"

module bch_key_solver (
	input wire clk,
	input wire reset,
	input wire syn_done,
	input wire gf_pkg::gf_elem_t syn_s1,
	input wire gf_pkg::gf_elem_t syn_s3,
	input wire bch_pkg::cw_t syn_word,
	output logic key_done,
	output gf_pkg::gf_elem_t key_sigma1,
	output gf_pkg::gf_elem_t key_sigma2,
	output bch_pkg::err_cnt_t key_errs,
	output bch_pkg::cw_t key_word
);
	gf_pkg::gf_elem_t s1_cube;
	gf_pkg::gf_elem_t div_numer;
	gf_pkg::gf_elem_t div_quot;
	logic div_start;
	logic div_busy;
	logic div_done;
	logic s3_match;
	bch_pkg::err_cnt_t errs;

	// sigma2 = (S3 + S1^3) / S1.
	assign div_numer = syn_s3 ^ s1_cube;
	assign s3_match = (syn_s3 == s1_cube);

	// Error count from the syndrome pattern.
	always_comb begin
		if (syn_s1 == '0)
			errs = s3_match ? bch_pkg::err_cnt_t'(0) : bch_pkg::ERR_FAIL;
		else
			errs = s3_match ? bch_pkg::err_cnt_t'(1) : bch_pkg::err_cnt_t'(2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			div_start <= 1'b0;
			key_done <= 1'b0;
		end else begin
			div_start <= syn_done;
			key_done <= div_done;
		end
	end

	always_ff @(posedge clk) begin
		if (syn_done)
			s1_cube <= gf_pkg::gf_mul(gf_pkg::gf_sqr(syn_s1), syn_s1);
		// Syndromes still stable, latch the whole result set.
		if (div_done) begin
			key_sigma1 <= syn_s1;
			key_sigma2 <= div_quot;
			key_errs <= errs;
			key_word <= syn_word;
		end
	end

	gf_divider u_divider (
		.clk(clk),
		.reset(reset),
		.start(div_start),
		.numer(div_numer),
		.denom(syn_s1),
		.quot(div_quot),
		.busy(div_busy),
		.done(div_done)
	);

	// Fixed latency, divider busy for m cycles in between.
	a_key_latency: assert property (@(posedge clk) disable iff (reset)
		syn_done |-> ##2 div_busy [* `BCH_M] ##1 key_done);
endmodule

`default_nettype wire

//--- hdl/bch_chien_search.sv
`default_nettype none

`include "bch_defines.svh"

module bch_chien_search (
	input wire clk,
	input wire reset,
	input wire key_done,
	input wire gf_pkg::gf_elem_t key_sigma1,
	input wire gf_pkg::gf_elem_t key_sigma2,
	input wire bch_pkg::err_cnt_t key_errs,
	input wire bch_pkg::cw_t key_word,
	output logic out_valid,
	output logic out_first,
	output logic out_bit,
	output logic out_last,
	output logic out_fail
);
	localparam bch_pkg::pos_t LAST_POS = bch_pkg::pos_t'(`BCH_N - 1);
	localparam gf_pkg::gf_elem_t GF_ONE = gf_pkg::gf_elem_t'(1);

	logic run;
	logic active;
	logic at_end;
	logic root;
	logic fail;
	bch_pkg::pos_t pos;
	bch_pkg::pos_t cur_pos;
	gf_pkg::gf_elem_t term1;
	gf_pkg::gf_elem_t term2;
	gf_pkg::gf_elem_t cur_t1;
	gf_pkg::gf_elem_t cur_t2;
	bch_pkg::err_cnt_t roots;
	bch_pkg::err_cnt_t cur_roots;

	// key_done cycle evaluates position N-1 straight from the inputs.
	assign active = key_done || run;
	assign cur_pos = key_done ? LAST_POS : pos;
	assign at_end = (cur_pos == '0);
	// Terms sigma1*x and sigma2*x^2 at x = alpha^(N-pos).
	assign cur_t1 = key_done ? gf_pkg::gf_mul_alpha(key_sigma1) : term1;
	assign cur_t2 = key_done ?
		gf_pkg::gf_mul_alpha(gf_pkg::gf_mul_alpha(key_sigma2)) : term2;
	// Locator 1 + t1 + t2 vanishes.
	assign root = ((cur_t1 ^ cur_t2) == GF_ONE);
	assign cur_roots = (key_done ? '0 : roots) + bch_pkg::err_cnt_t'(root);
	assign fail = (key_errs == bch_pkg::ERR_FAIL) || (cur_roots != key_errs);

	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
			out_valid <= 1'b0;
			out_first <= 1'b0;
			out_last <= 1'b0;
			out_fail <= 1'b0;
		end else begin
			run <= active && !at_end;
			out_valid <= active;
			out_first <= key_done;
			out_last <= active && at_end;
			out_fail <= active && at_end && fail;
		end
	end

	// Step x by alpha each cycle, flip the bit on a root.
	always_ff @(posedge clk) begin
		if (active) begin
			pos <= cur_pos - 1'b1;
			term1 <= gf_pkg::gf_mul_alpha(cur_t1);
			term2 <= gf_pkg::gf_mul_alpha(gf_pkg::gf_mul_alpha(cur_t2));
			roots <= cur_roots;
			out_bit <= key_word[cur_pos] ^ root;
		end
	end

	// Key stage spacing keeps words from overlapping here.
	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		key_done |-> !run);
endmodule

`default_nettype wire

//--- hdl/bch_decoder.sv
`default_nettype none

module bch_decoder (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire in_first,
	input wire in_bit,
	output logic out_valid,
	output logic out_first,
	output logic out_bit,
	output logic out_last,
	output logic out_fail
);
	// Syndrome stage to key solver.
	logic syn_done;
	gf_pkg::gf_elem_t syn_s1;
	gf_pkg::gf_elem_t syn_s3;
	bch_pkg::cw_t syn_word;

	// Key solver to Chien search.
	logic key_done;
	gf_pkg::gf_elem_t key_sigma1;
	gf_pkg::gf_elem_t key_sigma2;
	bch_pkg::err_cnt_t key_errs;
	bch_pkg::cw_t key_word;

	bch_syndrome u_syndrome (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_bit(in_bit),
		.syn_done(syn_done),
		.syn_s1(syn_s1),
		.syn_s3(syn_s3),
		.syn_word(syn_word)
	);

	bch_key_solver u_key_solver (
		.clk(clk),
		.reset(reset),
		.syn_done(syn_done),
		.syn_s1(syn_s1),
		.syn_s3(syn_s3),
		.syn_word(syn_word),
		.key_done(key_done),
		.key_sigma1(key_sigma1),
		.key_sigma2(key_sigma2),
		.key_errs(key_errs),
		.key_word(key_word)
	);

	bch_chien_search u_chien (
		.clk(clk),
		.reset(reset),
		.key_done(key_done),
		.key_sigma1(key_sigma1),
		.key_sigma2(key_sigma2),
		.key_errs(key_errs),
		.key_word(key_word),
		.out_valid(out_valid),
		.out_first(out_first),
		.out_bit(out_bit),
		.out_last(out_last),
		.out_fail(out_fail)
	);
endmodule

`default_nettype wire

//--- tests/bch_decoder_tb.sv
`default_nettype none

`include "bch_defines.svh"

module bch_decoder_tb;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 20;
	localparam int CLEAN_WORDS = 10;
	localparam int ONE_ERR_WORDS = 15;
	localparam int TWO_ERR_WORDS = 15;
	localparam int THREE_ERR_WORDS = 10;
	localparam int GAP_WORDS = 10;
	localparam int NUM_WORDS = CLEAN_WORDS + ONE_ERR_WORDS + TWO_ERR_WORDS +
		THREE_ERR_WORDS + GAP_WORDS;
	// A word with gaps takes at most one idle cycle per bit.
	localparam int WORD_CYCLES = `BCH_N + 2;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES +
		NUM_WORDS * WORD_CYCLES + GAP_WORDS * `BCH_N + 100;
	// Generator x^8 + x^7 + x^6 + x^4 + 1.
	localparam logic [8:0] GEN_POLY = 9'b1_1101_0001;
	localparam logic [31:0] SEED = 32'h5e0e_19ff;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_first;
	logic in_bit;
	// Marks the last bit of a word on the testbench side only.
	logic in_last;
	logic out_valid;
	logic out_first;
	logic out_bit;
	logic out_last;
	logic out_fail;

	integer seed;
	int cycle_cnt = 0;
	int words_started = 0;
	int words_done = 0;
	int rx_count = 0;
	bch_pkg::cw_t rx_word;
	// Clean codewords and injected error counts in send order.
	bch_pkg::cw_t exp_word_q[$];
	int exp_errs_q[$];

	bch_decoder UUT (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_bit(in_bit),
		.out_valid(out_valid),
		.out_first(out_first),
		.out_bit(out_bit),
		.out_last(out_last),
		.out_fail(out_fail)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Non-systematic encoder computing c(x) = m(x) * g(x).
	function automatic bch_pkg::cw_t encode_message(input logic [6:0] msg);
		bch_pkg::cw_t cw;
		cw = '0;
		for (int i = 0; i < 7; i++) begin
			if (msg[i])
				cw = cw ^ (bch_pkg::cw_t'(GEN_POLY) << i);
		end
		return cw;
	endfunction

	// Remainder of long division by g(x) is zero for every codeword.
	function automatic logic [7:0] gen_remainder(input bch_pkg::cw_t w);
		bch_pkg::cw_t r;
		r = w;
		for (int i = `BCH_N - 1; i >= 8; i--) begin
			if (r[i])
				r = r ^ (bch_pkg::cw_t'(GEN_POLY) << (i - 8));
		end
		return r[7:0];
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// Distinct error positions.
	task automatic make_error_mask(input int count, output bch_pkg::cw_t mask);
		int pos;
		mask = '0;
		while ($countones(mask) < count) begin
			pos = {$random(seed)} % `BCH_N;
			mask[pos] = 1'b1;
		end
	endtask

	// Highest-order bit first with an optional idle cycle before any bit.
	task automatic send_word(input logic [6:0] msg, input int errs, input bit gaps);
		bch_pkg::cw_t cw;
		bch_pkg::cw_t mask;
		cw = encode_message(msg);
		make_error_mask(errs, mask);
		exp_word_q.push_back(cw);
		exp_errs_q.push_back(errs);
		for (int i = `BCH_N - 1; i >= 0; i--) begin
			if (gaps && ($random(seed) & 3) == 0) begin
				@(posedge clk);
				in_valid <= 1'b0;
				in_first <= 1'b0;
				in_last <= 1'b0;
			end
			@(posedge clk);
			if (i == `BCH_N - 1)
				words_started++;
			in_valid <= 1'b1;
			in_first <= (i == `BCH_N - 1);
			in_bit <= cw[i] ^ mask[i];
			in_last <= (i == 0);
		end
	endtask

	// Negative errs picks 0, 1 or 2 per word.
	task automatic send_words(input int count, input int errs, input bit gaps);
		int n_err;
		logic [6:0] msg;
		for (int w = 0; w < count; w++) begin
			n_err = (errs < 0) ? {$random(seed)} % 3 : errs;
			msg = 7'($random(seed));
			send_word(msg, n_err, gaps);
		end
	endtask

	task automatic drive_idle();
		@(posedge clk);
		in_valid <= 1'b0;
		in_first <= 1'b0;
		in_bit <= 1'b0;
		in_last <= 1'b0;
	endtask

	// Compare one finished output word with the oldest sent word.
	task automatic check_word();
		bch_pkg::cw_t exp_word;
		int exp_errs;
		if (exp_word_q.size() == 0) begin
			stop_on_error("Output word arrived with no word sent");
		end else begin
			exp_word = exp_word_q.pop_front();
			exp_errs = exp_errs_q.pop_front();
			words_done++;
			assert (rx_count == `BCH_N)
				else stop_on_error($sformatf("FAIL out_valid count got 0x%h expected 0x%h",
					rx_count, `BCH_N));
			if (exp_errs <= 2) begin
				assert (rx_word == exp_word)
					else stop_on_error($sformatf("FAIL out_bit word got 0x%h expected 0x%h",
						rx_word, exp_word));
				assert (!out_fail)
					else stop_on_error("FAIL out_fail got 0x1 expected 0x0");
			end else begin
				// Three errors either flag or land on some codeword.
				assert (out_fail || gen_remainder(rx_word) == '0)
					else stop_on_error($sformatf("FAIL out_bit word 0x%h remainder 0x%h",
						rx_word, gen_remainder(rx_word)));
			end
		end
	endtask

	// Rebuild each output word MSB first.
	always @(posedge clk) begin : monitor
		if (!reset && out_valid) begin
			if (out_first) begin
				rx_word = bch_pkg::cw_t'(out_bit);
				rx_count = 1;
			end else if (rx_count == 0) begin
				stop_on_error("Output bit seen outside a word");
			end else begin
				rx_word = {rx_word[`BCH_N-2:0], out_bit};
				rx_count++;
			end
			if (out_last) begin
				check_word();
				// Closed word, the next bit must open a new one.
				rx_count = 0;
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
			stop_on_error($sformatf("Timeout after %0d cycles, words still missing",
				cycle_cnt));
	end

	// Nothing comes out unless a word went in.
	a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> words_started > words_done)
		else stop_on_error("Output valid while no word is pending");

	a_word_length: assert property (@(posedge clk) disable iff (reset)
		out_first |-> ##(`BCH_N - 1) out_last)
		else stop_on_error("FAIL out_last got 0x0 expected 0x1");

	// N consecutive valid cycles per word.
	a_word_run: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_last |=> out_valid)
		else stop_on_error("Gap in out_valid inside a word");

	a_word_start: assert property (@(posedge clk) disable iff (reset)
		out_last |=> !out_valid || out_first)
		else stop_on_error("FAIL out_first got 0x0 expected 0x1");

	a_fail_at_last: assert property (@(posedge clk) disable iff (reset)
		out_fail |-> out_last)
		else stop_on_error("FAIL out_last got 0x0 expected 0x1");

	// Fixed pipeline latency.
	a_latency: assert property (@(posedge clk) disable iff (reset)
		in_valid && in_last |-> ##(`BCH_M + 4) out_first)
		else stop_on_error("FAIL out_first got 0x0 expected 0x1");

	initial begin : stimulus
		seed = SEED;
		reset = 1'b1;
		in_valid = 1'b0;
		in_first = 1'b0;
		in_bit = 1'b0;
		in_last = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		repeat (IDLE_CYCLES) @(posedge clk);
		// Corner messages before random ones.
		send_word(7'h00, 0, 1'b0);
		send_word(7'h7f, 0, 1'b0);
		send_words(CLEAN_WORDS - 2, 0, 1'b0);
		send_words(ONE_ERR_WORDS, 1, 1'b0);
		send_words(TWO_ERR_WORDS, 2, 1'b0);
		send_words(THREE_ERR_WORDS, 3, 1'b0);
		send_words(GAP_WORDS, -1, 1'b1);
		drive_idle();
		while (words_done < NUM_WORDS)
			@(posedge clk);
		// Quiet tail.
		repeat (2 * `BCH_N) @(posedge clk);
		if (words_done == NUM_WORDS && exp_word_q.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			stop_on_error("Output word count does not match the words sent");
		end
	end
endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/gf_pkg.sv
hdl/bch_pkg.sv
hdl/gf_divider.sv
hdl/bch_syndrome.sv
hdl/bch_key_solver.sv
hdl/bch_chien_search.sv
hdl/bch_decoder.sv
tests/bch_decoder_tb.sv
